// File: design/merge_config.svh
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// ---- datapath --------
`define MERGE_DATA_WIDTH 40   // bits in one data word

// ---- structure -------
`define MERGE_NUM_IN     3    // number of input ports
`define MERGE_FIFO_DEPTH 8    // fifo entries, keep a power of two

`endif

// File: design/merge_pkg.sv
`include "merge_config.svh"

package merge_pkg;

  // ---- vectors ---------
  typedef logic [`MERGE_DATA_WIDTH-1:0] data_t;      // one payload word
  typedef logic [1:0]                   src_id_t;    // input port index

  // fifo entry is {last, src_id, data}, 43 bits
  typedef logic [`MERGE_DATA_WIDTH+2:0] entry_t;

  // pointer with one extra wrap bit on top of the address
  typedef logic [$clog2(`MERGE_FIFO_DEPTH):0] fifo_ptr_t;

  // ---- enums -----------
  typedef enum logic {
    word_rr    = 1'b0,   // give up grant after every word
    frame_lock = 1'b1    // hold grant until last word of frame
  } arb_mode_e;

  typedef enum logic [1:0] {
    run_idle,            // waiting for proc_req
    run_busy,            // frames in flight
    run_ack              // single proc_ack cycle
  } run_state_e;

endpackage

// File: design/chan_if.sv
`timescale 1ns/1ps

// held word of one input channel, seen by the arbiter
interface chan_if;
  import merge_pkg::*;

  logic  valid;   // register stage holds a word
  data_t data;    // held payload
  logic  last;    // held word closes its frame
  logic  take;    // arbiter moves the word into the fifo this cycle

  // register stage side
  modport chan (output valid, output data, output last, input take);

  // arbiter side
  modport arb (input valid, input data, input last, output take);

endinterface

// File: design/run_control.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module run_control import merge_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     proc_req,               // start request, idle only
  input  logic                     proc_req_in0_en,
  input  logic                     proc_req_in1_en,
  input  logic                     proc_req_in2_en,
  input  arb_mode_e                proc_req_in0_arb_mode,
  input  arb_mode_e                proc_req_in1_arb_mode,
  input  arb_mode_e                proc_req_in2_arb_mode,
  input  logic                     frame_done,             // last word left the output
  output logic [`MERGE_NUM_IN-1:0] in_en,                  // per input enable for the run
  output arb_mode_e                arb_mode [`MERGE_NUM_IN],
  output logic                     run_start,              // first busy cycle
  output logic                     proc_ack
);

  localparam int cnt_w = $clog2(`MERGE_NUM_IN + 1);  // wide enough for all inputs

  run_state_e              state_q, state_d;
  logic                    run_start_q;
  logic [`MERGE_NUM_IN-1:0] in_en_q;
  arb_mode_e               arb_mode_q [`MERGE_NUM_IN];
  logic [cnt_w-1:0]        frame_cnt_q;                   // finished frames this run
  logic [cnt_w-1:0]        cnt_next;
  logic [cnt_w-1:0]        num_en;                        // frames expected this run

  // ---- frame count -----
  always_comb begin
    num_en = '0;
    for (int i = 0; i < `MERGE_NUM_IN; i++) begin
      num_en = num_en + cnt_w'(in_en_q[i]);
    end
  end

  assign cnt_next = frame_cnt_q + cnt_w'(frame_done);  // count includes this cycle's pulse

  // ---- fsm -------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      run_idle: if (proc_req) state_d = run_busy;
      run_busy: if (cnt_next == num_en) state_d = run_ack;  // zero enables ends at once
      run_ack:  state_d = run_idle;                          // one cycle only
      default:  state_d = run_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= run_idle;
      run_start_q <= 1'b0;
      in_en_q     <= '0;
      frame_cnt_q <= '0;
      arb_mode_q  <= '{default: word_rr};
    end else begin
      state_q     <= state_d;
      run_start_q <= (state_q == run_idle) && proc_req;
      if ((state_q == run_idle) && proc_req) begin
        // capture the run configuration
        in_en_q       <= {proc_req_in2_en, proc_req_in1_en, proc_req_in0_en};
        arb_mode_q[0] <= proc_req_in0_arb_mode;
        arb_mode_q[1] <= proc_req_in1_arb_mode;
        arb_mode_q[2] <= proc_req_in2_arb_mode;
        frame_cnt_q   <= '0;
      end else if (state_q == run_busy) begin
        frame_cnt_q <= cnt_next;
        if (state_d == run_ack) in_en_q <= '0;  // run over, close the inputs
      end
    end
  end

  assign in_en     = in_en_q;
  assign arb_mode  = arb_mode_q;
  assign run_start = run_start_q;
  assign proc_ack  = (state_q == run_ack);

endmodule

// File: design/input_channel.sv
`timescale 1ns/1ps

module input_channel import merge_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_en,          // input enabled for this run
  input  logic  in_valid,
  input  data_t in_data,
  input  logic  in_data_last,
  output logic  in_ready,
  chan_if.chan  ch              // held word towards the arbiter
);

  logic  full_q;   // register holds a word
  data_t data_q;
  logic  last_q;
  logic  accept;   // input handshake this cycle

  // ---- handshake -------
  // one word per cycle passes when the held word leaves in the same cycle
  assign in_ready = in_en && (!full_q || ch.take);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;            // new word, or replacement of the taken one
    end else if (ch.take) begin
      full_q <= 1'b0;            // drained and nothing new
    end
  end

  // payload only moves on a handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= in_data;
      last_q <= in_data_last;
    end
  end

  // ---- to arbiter ------
  assign ch.valid = full_q;
  assign ch.data  = data_q;
  assign ch.last  = last_q;

endmodule

// File: design/frame_arbiter.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module frame_arbiter import merge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run_start,                   // clears the rr pointer
  input  arb_mode_e arb_mode [`MERGE_NUM_IN],
  input  logic      fifo_full,
  chan_if.arb       ch0,
  chan_if.arb       ch1,
  chan_if.arb       ch2,
  output logic      fifo_we,
  output entry_t    fifo_wdata
);

  // pointer value that makes the next search start at input 0
  localparam src_id_t last_id = src_id_t'(`MERGE_NUM_IN - 1);

  logic [`MERGE_NUM_IN-1:0] valid_v;
  logic [`MERGE_NUM_IN-1:0] last_v;
  data_t                    data_a [`MERGE_NUM_IN];

  src_id_t ptr_q;       // last granted input
  logic    lock_q;      // frame_lock grant held
  src_id_t lock_id_q;   // owner of the lock
  logic    gnt_vld;     // some input granted this cycle
  src_id_t gnt_id;
  logic    xfer;        // word moves into the fifo

  // ---- gather channels -
  assign valid_v   = {ch2.valid, ch1.valid, ch0.valid};
  assign last_v    = {ch2.last, ch1.last, ch0.last};
  assign data_a[0] = ch0.data;
  assign data_a[1] = ch1.data;
  assign data_a[2] = ch2.data;

  // ---- grant -----------
  always_comb begin
    int unsigned cand;
    gnt_vld = 1'b0;
    gnt_id  = '0;
    cand    = 0;
    if (lock_q) begin
      // locked owner only, others wait even when valid
      gnt_vld = valid_v[lock_id_q];
      gnt_id  = lock_id_q;
    end else begin
      for (int i = 1; i <= `MERGE_NUM_IN; i++) begin
        cand = (int'(ptr_q) + i) % `MERGE_NUM_IN;  // search after last grant
        if (!gnt_vld && valid_v[cand]) begin
          gnt_vld = 1'b1;
          gnt_id  = src_id_t'(cand);
        end
      end
    end
  end

  assign xfer = gnt_vld && !fifo_full;

  // take and we fall together, only with room in the fifo
  assign ch0.take = xfer && (gnt_id == 2'd0);
  assign ch1.take = xfer && (gnt_id == 2'd1);
  assign ch2.take = xfer && (gnt_id == 2'd2);

  assign fifo_we    = xfer;
  assign fifo_wdata = {last_v[gnt_id], gnt_id, data_a[gnt_id]};  // {last, src, data}

  // ---- state -----------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q     <= last_id;
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else if (run_start) begin
      ptr_q  <= last_id;   // fresh run starts at input 0
      lock_q <= 1'b0;
    end else if (xfer) begin
      ptr_q     <= gnt_id;
      // frame_lock keeps the grant until the last word is taken
      lock_q    <= (arb_mode[gnt_id] == frame_lock) && !last_v[gnt_id];
      lock_id_q <= gnt_id;
    end
  end

endmodule

// File: design/merge_fifo.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module merge_fifo import merge_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fifo_we,       // push, only while not full
  input  entry_t fifo_wdata,
  input  logic   fifo_re,       // pop, only while not empty
  output logic   fifo_full,
  output entry_t fifo_rdata,    // head entry, combinational
  output logic   fifo_empty
);

  localparam int addr_w = $clog2(`MERGE_FIFO_DEPTH);

  entry_t    mem [`MERGE_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;   // msb is the wrap bit
  fifo_ptr_t rd_ptr_q;
  logic      do_wr;
  logic      do_rd;

  assign do_wr = fifo_we && !fifo_full;
  assign do_rd = fifo_re && !fifo_empty;

  // ---- pointers --------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q[addr_w-1:0]] <= fifo_wdata;  // readable from next cycle
    end
  end

  // ---- status ----------
  // same address, wrap bits differ -> full; identical -> empty
  assign fifo_full  = (wr_ptr_q[addr_w] != rd_ptr_q[addr_w]) &&
                      (wr_ptr_q[addr_w-1:0] == rd_ptr_q[addr_w-1:0]);
  assign fifo_empty = (wr_ptr_q == rd_ptr_q);

  assign fifo_rdata = mem[rd_ptr_q[addr_w-1:0]];

endmodule

// File: design/output_control.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module output_control import merge_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fifo_empty,
  input  entry_t  fifo_rdata,            // {last, src, data}
  input  logic    out_ready,
  output logic    fifo_re,
  output logic    out_valid,
  output data_t   out_data,
  output src_id_t out_data_source_id,
  output logic    out_data_last,
  output logic    frame_done             // last word accepted
);

  logic    valid_q;
  data_t   data_q;
  src_id_t src_q;
  logic    last_q;

  // ---- refill ----------
  // pop when the register is empty or its word leaves this cycle
  assign fifo_re = !fifo_empty && (!valid_q || out_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (fifo_re) begin
      valid_q <= 1'b1;
    end else if (out_ready) begin
      valid_q <= 1'b0;   // word gone, fifo had nothing
    end
  end

  // unpack the head entry into the output register
  always_ff @(posedge clk) begin
    if (fifo_re) begin
      data_q <= fifo_rdata[`MERGE_DATA_WIDTH-1:0];
      src_q  <= fifo_rdata[`MERGE_DATA_WIDTH +: 2];
      last_q <= fifo_rdata[`MERGE_DATA_WIDTH+2];
    end
  end

  // ---- outputs ---------
  assign out_valid          = valid_q;
  assign out_data           = data_q;
  assign out_data_source_id = src_q;
  assign out_data_last      = last_q;

  assign frame_done = valid_q && out_ready && last_q;  // end of one input's frame

endmodule

// File: design/stream_merge_top.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module stream_merge_top import merge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // run control
  input  logic      proc_req,
  input  logic      proc_req_in0_en,
  input  arb_mode_e proc_req_in0_arb_mode,
  input  logic      proc_req_in1_en,
  input  arb_mode_e proc_req_in1_arb_mode,
  input  logic      proc_req_in2_en,
  input  arb_mode_e proc_req_in2_arb_mode,
  output logic      proc_ack,
  // input 0
  input  logic      in0_valid,
  output logic      in0_ready,
  input  data_t     in0_data,
  input  logic      in0_data_last,
  // input 1
  input  logic      in1_valid,
  output logic      in1_ready,
  input  data_t     in1_data,
  input  logic      in1_data_last,
  // input 2
  input  logic      in2_valid,
  output logic      in2_ready,
  input  data_t     in2_data,
  input  logic      in2_data_last,
  // merged output
  output logic      out_valid,
  input  logic      out_ready,
  output data_t     out_data,
  output src_id_t   out_data_source_id,   // input the word came from
  output logic      out_data_last
);

  logic [`MERGE_NUM_IN-1:0] in_en;
  arb_mode_e                arb_mode [`MERGE_NUM_IN];
  logic                     run_start;
  logic                     frame_done;
  logic                     fifo_we, fifo_re, fifo_full, fifo_empty;
  entry_t                   fifo_wdata, fifo_rdata;

  chan_if ch0_if ();   // held word of each input
  chan_if ch1_if ();
  chan_if ch2_if ();

  run_control run_control_inst (
    .clk, .rst_n, .proc_req,
    .proc_req_in0_en, .proc_req_in1_en, .proc_req_in2_en,
    .proc_req_in0_arb_mode, .proc_req_in1_arb_mode, .proc_req_in2_arb_mode,
    .frame_done, .in_en, .arb_mode, .run_start, .proc_ack
  );

  // ---- input stages ----
  input_channel in_chan0_inst (
    .clk, .rst_n, .in_en(in_en[0]), .in_valid(in0_valid), .in_data(in0_data),
    .in_data_last(in0_data_last), .in_ready(in0_ready), .ch(ch0_if.chan)
  );
  input_channel in_chan1_inst (
    .clk, .rst_n, .in_en(in_en[1]), .in_valid(in1_valid), .in_data(in1_data),
    .in_data_last(in1_data_last), .in_ready(in1_ready), .ch(ch1_if.chan)
  );
  input_channel in_chan2_inst (
    .clk, .rst_n, .in_en(in_en[2]), .in_valid(in2_valid), .in_data(in2_data),
    .in_data_last(in2_data_last), .in_ready(in2_ready), .ch(ch2_if.chan)
  );

  // ---- merge path ------
  frame_arbiter frame_arbiter_inst (
    .clk, .rst_n, .run_start, .arb_mode, .fifo_full,
    .ch0(ch0_if.arb), .ch1(ch1_if.arb), .ch2(ch2_if.arb),
    .fifo_we, .fifo_wdata
  );

  merge_fifo merge_fifo_inst (
    .clk, .rst_n, .fifo_we, .fifo_wdata, .fifo_re,
    .fifo_full, .fifo_rdata, .fifo_empty
  );

  output_control output_control_inst (
    .clk, .rst_n, .fifo_empty, .fifo_rdata, .out_ready, .fifo_re,
    .out_valid, .out_data, .out_data_source_id, .out_data_last, .frame_done
  );

endmodule

// File: tests/tb_stream_merge.sv
`timescale 1ns/1ps
`include "merge_config.svh"

module tb_stream_merge import merge_pkg::*; ();

  localparam int num_runs   = 40;
  localparam int wait_limit = 2000;   // cycles before any wait gives up

  typedef logic [`MERGE_DATA_WIDTH:0] word_t;  // {last, data} as accepted at an input

  logic      clk;
  logic      rst_n;
  logic      proc_req;
  logic      [2:0] en_cfg;           // enables of the current run
  arb_mode_e mode_cfg [3];           // modes of the current run
  logic      [2:0] in_valid;
  data_t     in_data [3];
  logic      [2:0] in_last;
  wire       [2:0] in_ready;
  logic      out_ready;
  logic      out_valid;
  data_t     out_data;
  src_id_t   out_data_source_id;
  logic      out_data_last;
  logic      proc_ack;

  // ---- model state ----
  word_t   q0 [$];                   // expected words per source in order
  word_t   q1 [$];
  word_t   q2 [$];
  int      frames_out;               // last words seen at the output this run
  int      err_count;
  logic    run_active;
  logic    lock_active;              // frame_lock frame in progress on the output
  src_id_t lock_src;
  logic    ack_exp;                  // proc_ack expected at the next edge
  logic    zero_wait;                // run without inputs acks one cycle later

  stream_merge_top dut_i (
    .clk, .rst_n, .proc_req,
    .proc_req_in0_en(en_cfg[0]), .proc_req_in0_arb_mode(mode_cfg[0]),
    .proc_req_in1_en(en_cfg[1]), .proc_req_in1_arb_mode(mode_cfg[1]),
    .proc_req_in2_en(en_cfg[2]), .proc_req_in2_arb_mode(mode_cfg[2]),
    .proc_ack,
    .in0_valid(in_valid[0]), .in0_ready(in_ready[0]), .in0_data(in_data[0]),
    .in0_data_last(in_last[0]),
    .in1_valid(in_valid[1]), .in1_ready(in_ready[1]), .in1_data(in_data[1]),
    .in1_data_last(in_last[1]),
    .in2_valid(in_valid[2]), .in2_ready(in_ready[2]), .in2_data(in_data[2]),
    .in2_data_last(in_last[2]),
    .out_valid, .out_ready, .out_data, .out_data_source_id, .out_data_last
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;          // 40 ns period
  end

  // ---- checks ---------
  task automatic report_failure(input string msg);
    err_count++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
      report_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_src(input string name, input src_id_t exp, input src_id_t act);
    if (act !== exp)
      report_failure($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  // ---- queues ---------
  function automatic int queue_size(input int idx);
    case (idx)
      0: return q0.size();
      1: return q1.size();
      default: return q2.size();
    endcase
  endfunction

  task automatic push_word(input int idx, input word_t w);
    case (idx)
      0: q0.push_back(w);
      1: q1.push_back(w);
      default: q2.push_back(w);
    endcase
  endtask

  function automatic word_t pop_word(input int idx);
    case (idx)
      0: return q0.pop_front();
      1: return q1.pop_front();
      default: return q2.pop_front();
    endcase
  endfunction

  function automatic int count_enabled();
    return int'(en_cfg[0]) + int'(en_cfg[1]) + int'(en_cfg[2]);
  endfunction

  // one output word against the model
  task automatic check_output();
    src_id_t src;
    word_t   exp;
    src = out_data_source_id;
    if (src > 2 || !en_cfg[src])
      report_failure($sformatf("output word carries the ID %0d of a disabled input", src));
    if (lock_active) check_src("out_data_source_id", lock_src, src);  // frame_lock interleave
    if (queue_size(src) == 0)
      report_failure($sformatf("output word from input %0d without a matching input word", src));
    exp = pop_word(src);
    check_data("out_data", exp[`MERGE_DATA_WIDTH-1:0], out_data);
    check_last("out_data_last", exp[`MERGE_DATA_WIDTH], out_data_last);
    lock_active = (mode_cfg[src] == frame_lock) && !out_data_last;
    lock_src    = src;
    if (out_data_last) begin
      frames_out++;
      if (frames_out == count_enabled()) ack_exp = 1'b1;  // ack one cycle later
    end
  endtask

  // ---- monitor --------
  // samples at the rising edge while inputs change 1 ns later
  always @(posedge clk) begin
    if (rst_n) begin
      check_ack("proc_ack", ack_exp, proc_ack);
      ack_exp = 1'b0;
      if (proc_ack) run_active = 1'b0;
      if (zero_wait) begin
        ack_exp   = 1'b1;
        zero_wait = 1'b0;
      end
      if (proc_req) begin
        run_active  = 1'b1;
        frames_out  = 0;
        lock_active = 1'b0;
        zero_wait   = (count_enabled() == 0);
      end
      for (int i = 0; i < 3; i++) begin
        if (in_ready[i] && !(run_active && en_cfg[i]))
          report_failure($sformatf("in%0d_ready high while the input is disabled", i));
        if (in_valid[i] && in_ready[i]) push_word(i, {in_last[i], in_data[i]});
      end
      if (out_valid && out_ready) check_output();
    end
  end

  // random back-pressure on the output
  initial begin
    forever begin
      @(posedge clk);
      #1 out_ready = ($urandom_range(0, 3) != 0);
    end
  end

  // ---- stimulus -------
  // entered and left 1 ns after a rising edge
  task automatic send_frame(input int idx, input int len);
    int gap;
    int cycles;
    for (int w = 0; w < len; w++) begin
      gap = $urandom_range(0, 2);
      if (gap > 0) begin
        in_valid[idx] = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      in_valid[idx] = 1'b1;
      in_data[idx]  = data_t'({$urandom, $urandom});
      in_last[idx]  = (w == len - 1);
      cycles = 0;
      @(posedge clk);
      while (!in_ready[idx]) begin
        cycles++;
        if (cycles > wait_limit)
          report_failure($sformatf("timeout: in%0d_ready never rose for word %0d", idx, w));
        @(posedge clk);
      end
      #1;
    end
    in_valid[idx] = 1'b0;
  endtask

  task automatic wait_for_ack();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!proc_ack) begin
      cycles++;
      if (cycles > wait_limit) report_failure("timeout: proc_ack never came at the end of a run");
      @(posedge clk);
    end
  endtask

  initial begin
    int len [3];
    void'($urandom(6));              // one seed for the whole run
    rst_n       = 1'b0;
    proc_req    = 1'b0;
    en_cfg      = '0;
    mode_cfg    = '{default: word_rr};
    in_valid    = '0;
    in_last     = '0;
    in_data     = '{default: '0};
    out_ready   = 1'b0;
    err_count   = 0;
    frames_out  = 0;
    run_active  = 1'b0;
    lock_active = 1'b0;
    lock_src    = '0;
    ack_exp     = 1'b0;
    zero_wait   = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    check_ack("proc_ack", 1'b0, proc_ack);  // quiet after reset
    check_flag("out_valid", 1'b0, out_valid);
    for (int i = 0; i < 3; i++) check_flag($sformatf("in%0d_ready", i), 1'b0, in_ready[i]);
    for (int run = 0; run < num_runs; run++) begin
      en_cfg = 3'($urandom_range(0, 7));
      if (run % 10 == 3) en_cfg = '0;  // some runs without any input
      for (int i = 0; i < 3; i++) begin
        len[i]      = $urandom_range(1, 6);
        mode_cfg[i] = arb_mode_e'($urandom_range(0, 1));
        if (!en_cfg[i]) begin
          // disabled input offers words for the whole run
          in_valid[i] = 1'b1;
          in_data[i]  = data_t'({$urandom, $urandom});
          in_last[i]  = 1'($urandom_range(0, 1));
        end
      end
      proc_req = 1'b1;
      @(posedge clk);
      #1 proc_req = 1'b0;
      fork
        if (en_cfg[0]) send_frame(0, len[0]);
        if (en_cfg[1]) send_frame(1, len[1]);
        if (en_cfg[2]) send_frame(2, len[2]);
      join
      wait_for_ack();
      #1;
      in_valid = '0;
      if (q0.size() + q1.size() + q2.size() != 0)
        report_failure("input words still missing at the output after proc_ack");
    end
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/merge_pkg.sv
design/chan_if.sv
design/run_control.sv
design/input_channel.sv
design/frame_arbiter.sv
design/merge_fifo.sv
design/output_control.sv
design/stream_merge_top.sv
tests/tb_stream_merge.sv
